/* cachePkg.sv */
//--------------------
// Data cache package
// Sizes, address split, controller states and the
// command and lookup structs shared by the cache blocks
//--------------------
package cachePkg;

    //--------------------
    // Sizes
    //--------------------
    localparam int WordBits      = 32;
    localparam int NumWays       = 2;
    localparam int WordsPerBlock = 4;
    localparam int NumSets       = 4;
    localparam int ByteBits      = 2;
    localparam int OffsetBits    = 2;
    localparam int SetBits       = 2;
    // Whatever is left above byte, word and set bits
    localparam int TagBits       = WordBits - ByteBits - OffsetBits - SetBits;

    // Bit positions of the address fields
    localparam int OffsetLsb = ByteBits;
    localparam int SetLsb    = OffsetLsb + OffsetBits;
    localparam int TagLsb    = SetLsb + SetBits;

    //--------------------
    // Vector types
    //--------------------
    typedef logic [WordBits-1:0]   wordT;
    typedef logic [WordBits-1:0]   addrT;
    typedef logic [TagBits-1:0]    tagT;
    typedef logic [SetBits-1:0]    setT;
    typedef logic [OffsetBits-1:0] offsetT;
    typedef logic [3:0]            byteMaskT;

    localparam byteMaskT FullMask = 4'hF;
    // Index of the last word of a block
    localparam offsetT LastBeat = offsetT'(WordsPerBlock - 1);

    // Read data select codes
    localparam logic [1:0] RdCache = 2'd0;
    localparam logic [1:0] RdBus   = 2'd1;
    localparam logic [1:0] RdWd    = 2'd2;

    // Controller states
    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        Fetch,
        Uncached
    } ctrlStateT;

    //--------------------
    // Structs between blocks
    //--------------------
    // Tag lookup result for the addressed set
    typedef struct packed {
        logic hit;
        logic hitWay;
        logic victimWay;
        logic victimDirty;
        tagT  victimTag;
    } lookupT;

    // Array commands from the controller
    typedef struct packed {
        logic     wordWe;
        byteMaskT byteMask;
        logic     fillWay;
        logic     setValid;
        logic     setDirty;
        logic     clearDirty;
        logic     touchLru;
    } memCtrlT;

    // Datapath selects from the controller
    typedef struct packed {
        offsetT     wordCount;
        logic       useCounter;
        logic       useCacheAddr;
        logic       useWd;
        logic [1:0] rdSel;
    } pathCtrlT;

endpackage

/* cacheController.sv */
//--------------------
// Data cache controller
// FSM that sequences hits, dirty write-back, block fill
// and uncached single-word transfers, and drives Stall
//--------------------
`timescale 1ns/1ps

module cacheController (
    input  logic               clk,
    input  logic               rstN,
    input  logic               enable,
    input  logic               MemWriteM,
    input  logic               MemtoRegM,
    input  logic               IStall,
    input  logic               BusReady,
    input  cachePkg::byteMaskT ByteMask,
    input  cachePkg::lookupT   lookup,
    input  cachePkg::offsetT   wordOffset,
    output cachePkg::memCtrlT  memCtrl,
    output cachePkg::pathCtrlT pathCtrl,
    output logic               Stall,
    output logic               HRequestM,
    output logic               HWriteM
);
    import cachePkg::*;

    ctrlStateT state, nextState;
    // Word currently on the bus, starts at the requested word
    offsetT wordCount;
    // Bus words done in this phase
    offsetT beatCount;
    logic   access;
    logic   lastBeat;

    assign access   = MemWriteM | MemtoRegM;
    assign lastBeat = BusReady && (beatCount == LastBeat);

    //--------------------
    // State and counters
    //--------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= Idle;
            wordCount <= '0;
            beatCount <= '0;
        end else begin
            state <= nextState;
            if (state == Idle) begin
                // Critical word goes first
                wordCount <= wordOffset;
                beatCount <= '0;
            end else if (BusReady && (state != Uncached)) begin
                // Both counters wrap, so Fetch restarts where WriteBack began
                wordCount <= wordCount + 1'b1;
                beatCount <= beatCount + 1'b1;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (access && !enable)
                    nextState = Uncached;
                else if (access && !lookup.hit)
                    nextState = lookup.victimDirty ? WriteBack : Fetch;
            end
            WriteBack: if (lastBeat) nextState = Fetch;
            Fetch:     if (lastBeat) nextState = Idle;
            Uncached:  if (BusReady) nextState = Idle;
            default:   nextState = Idle;
        endcase
    end

    //--------------------
    // Outputs per state
    //--------------------
    always_comb begin
        memCtrl  = '0;
        pathCtrl = '0;
        pathCtrl.wordCount = wordCount;
        Stall     = 1'b0;
        HRequestM = 1'b0;
        HWriteM   = 1'b0;
        case (state)
            Idle: begin
                pathCtrl.useWd = 1'b1;
                pathCtrl.rdSel = RdCache;
                Stall = access && (!enable || !lookup.hit);
                // Hit work commits only with the pipeline moving
                if (access && enable && lookup.hit && !IStall) begin
                    memCtrl.fillWay  = lookup.hitWay;
                    memCtrl.touchLru = 1'b1;
                    if (MemWriteM) begin
                        memCtrl.wordWe   = 1'b1;
                        memCtrl.byteMask = ByteMask;
                        memCtrl.setDirty = 1'b1;
                    end
                end
            end
            WriteBack: begin
                // Victim words go out at the victim's address
                pathCtrl.useCounter   = 1'b1;
                pathCtrl.useCacheAddr = 1'b1;
                Stall     = 1'b1;
                HRequestM = 1'b1;
                HWriteM   = 1'b1;
            end
            Fetch: begin
                pathCtrl.useCounter = 1'b1;
                Stall     = 1'b1;
                HRequestM = 1'b1;
                memCtrl.fillWay  = lookup.victimWay;
                memCtrl.byteMask = FullMask;
                memCtrl.wordWe   = BusReady;
                // Block complete on the last word
                if (lastBeat) begin
                    memCtrl.setValid   = 1'b1;
                    memCtrl.clearDirty = 1'b1;
                    memCtrl.touchLru   = 1'b1;
                end
            end
            Uncached: begin
                pathCtrl.useWd = 1'b1;
                pathCtrl.rdSel = MemWriteM ? RdWd : RdBus;
                // Data is ready in the BusReady cycle
                Stall     = !BusReady;
                HRequestM = 1'b1;
                HWriteM   = MemWriteM;
            end
            default: Stall = 1'b0;
        endcase
    end

    //--------------------
    // Checks
    //--------------------
    // Idle without a stall stays in Idle, so the bus stays quiet
    idleNoRequest: assert property (@(posedge clk) disable iff (!rstN)
        (state == Idle && !Stall) |=> !HRequestM);

    // A cached hit never stalls, so no block move runs while the lookup hits
    hitNoStall: assert property (@(posedge clk) disable iff (!rstN)
        (state != Uncached && enable && access && lookup.hit) |-> !Stall);

endmodule

/* cacheMemory.sv */
//--------------------
// Data cache arrays
// Data, tag, valid and dirty storage for both ways,
// LRU bit per set, tag compare and victim choice
//--------------------
`timescale 1ns/1ps

module cacheMemory (
    input  logic              clk,
    input  logic              rstN,
    input  cachePkg::setT     set,
    input  cachePkg::tagT     tag,
    input  cachePkg::offsetT  offset,
    input  cachePkg::wordT    writeData,
    input  cachePkg::memCtrlT memCtrl,
    output cachePkg::lookupT  lookup,
    output cachePkg::wordT    way0Word,
    output cachePkg::wordT    way1Word
);
    import cachePkg::*;

    // Payload storage
    wordT dataArray [NumWays][NumSets][WordsPerBlock];
    tagT  tagArray  [NumWays][NumSets];

    // Control bits per way and set
    logic [NumWays-1:0][NumSets-1:0] validArray;
    logic [NumWays-1:0][NumSets-1:0] dirtyArray;
    // Way that was used least recently, per set
    logic [NumSets-1:0] lruBits;

    logic hit0, hit1;
    logic victim;

    //--------------------
    // Lookup
    //--------------------
    assign hit0 = validArray[0][set] && (tagArray[0][set] == tag);
    assign hit1 = validArray[1][set] && (tagArray[1][set] == tag);

    // An empty way wins over the LRU way
    always_comb begin
        if (!validArray[0][set])
            victim = 1'b0;
        else if (!validArray[1][set])
            victim = 1'b1;
        else
            victim = lruBits[set];
    end

    assign lookup.hit         = hit0 | hit1;
    assign lookup.hitWay      = hit1;
    assign lookup.victimWay   = victim;
    assign lookup.victimDirty = validArray[victim][set] && dirtyArray[victim][set];
    assign lookup.victimTag   = tagArray[victim][set];

    // Selected word of each way
    assign way0Word = dataArray[0][set][offset];
    assign way1Word = dataArray[1][set][offset];

    //--------------------
    // Payload writes
    //--------------------
    always_ff @(posedge clk) begin
        if (memCtrl.wordWe) begin
            for (int b = 0; b < 4; b++) begin
                if (memCtrl.byteMask[b])
                    dataArray[memCtrl.fillWay][set][offset][8*b +: 8] <= writeData[8*b +: 8];
            end
        end
        // Tag goes in with the valid bit at the end of a fill
        if (memCtrl.setValid)
            tagArray[memCtrl.fillWay][set] <= tag;
    end

    //--------------------
    // Valid, dirty, LRU
    //--------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validArray <= '0;
            dirtyArray <= '0;
            lruBits    <= '0;
        end else begin
            if (memCtrl.setValid)
                validArray[memCtrl.fillWay][set] <= 1'b1;
            if (memCtrl.clearDirty)
                dirtyArray[memCtrl.fillWay][set] <= 1'b0;
            else if (memCtrl.setDirty)
                dirtyArray[memCtrl.fillWay][set] <= 1'b1;
            // The other way becomes the older one
            if (memCtrl.touchLru)
                lruBits[set] <= ~memCtrl.fillWay;
        end
    end

    // One block never sits in both ways
    singleHit: assert property (@(posedge clk) disable iff (!rstN)
        !(hit0 && hit1));

endmodule

/* cacheDatapath.sv */
//--------------------
// Data cache datapath
// Address build, cache and bus write data, bus address
// and read data selection
//--------------------
`timescale 1ns/1ps

module cacheDatapath (
    input  cachePkg::addrT     A,
    input  cachePkg::wordT     WD,
    input  cachePkg::wordT     HRData,
    input  cachePkg::pathCtrlT pathCtrl,
    input  cachePkg::lookupT   lookup,
    input  cachePkg::wordT     way0Word,
    input  cachePkg::wordT     way1Word,
    output cachePkg::setT      set,
    output cachePkg::tagT      tag,
    output cachePkg::offsetT   offset,
    output cachePkg::wordT     cacheWd,
    output cachePkg::addrT     HAddr,
    output cachePkg::wordT     HWData,
    output cachePkg::wordT     RD
);
    import cachePkg::*;

    // Address with the counter as word offset during block moves
    addrT effAddr;
    wordT hitWord;
    wordT victimWord;

    always_comb begin
        effAddr = A;
        if (pathCtrl.useCounter)
            effAddr[SetLsb-1:OffsetLsb] = pathCtrl.wordCount;
    end

    //--------------------
    // Address fields
    //--------------------
    assign tag    = effAddr[WordBits-1:TagLsb];
    assign set    = effAddr[TagLsb-1:SetLsb];
    assign offset = effAddr[SetLsb-1:OffsetLsb];

    // Write-back targets the victim's block, same set and word
    assign HAddr = pathCtrl.useCacheAddr ? {lookup.victimTag, effAddr[TagLsb-1:0]}
                                         : effAddr;

    //--------------------
    // Data muxes
    //--------------------
    assign hitWord    = lookup.hitWay    ? way1Word : way0Word;
    assign victimWord = lookup.victimWay ? way1Word : way0Word;

    // Fill data from the bus, store data from the pipeline
    assign cacheWd = pathCtrl.useWd ? WD : HRData;
    // Victim word on write-back, pipeline data when uncached
    assign HWData  = pathCtrl.useWd ? WD : victimWord;

    always_comb begin
        case (pathCtrl.rdSel)
            RdCache: RD = hitWord;
            RdBus:   RD = HRData;
            RdWd:    RD = WD;
            default: RD = hitWord;
        endcase
    end

endmodule

/* dataWritebackCache.sv */
//--------------------
// Two-way write-back data cache
// Joins the controller, the arrays and the datapath
//--------------------
`timescale 1ns/1ps

module dataWritebackCache (
    input  logic               clk,
    input  logic               rstN,
    input  logic               enable,
    input  logic               MemWriteM,
    input  logic               MemtoRegM,
    input  logic               IStall,
    input  cachePkg::addrT     A,
    input  cachePkg::wordT     WD,
    input  cachePkg::byteMaskT ByteMask,
    input  cachePkg::wordT     HRData,
    input  logic               BusReady,
    output cachePkg::wordT     RD,
    output logic               Stall,
    output cachePkg::addrT     HAddr,
    output cachePkg::wordT     HWData,
    output logic               HRequestM,
    output logic               HWriteM
);
    import cachePkg::*;

    // Controller commands
    memCtrlT  memCtrl;
    pathCtrlT pathCtrl;
    lookupT   lookup;

    // Effective address fields
    setT    set;
    tagT    tag;
    offsetT offset;

    // Data between arrays and datapath
    wordT way0Word, way1Word;
    wordT cacheWd;

    cacheController cacheController_inst (
        .clk        (clk),
        .rstN       (rstN),
        .enable     (enable),
        .MemWriteM  (MemWriteM),
        .MemtoRegM  (MemtoRegM),
        .IStall     (IStall),
        .BusReady   (BusReady),
        .ByteMask   (ByteMask),
        .lookup     (lookup),
        .wordOffset (offset),
        .memCtrl    (memCtrl),
        .pathCtrl   (pathCtrl),
        .Stall      (Stall),
        .HRequestM  (HRequestM),
        .HWriteM    (HWriteM)
    );

    cacheMemory cacheMemory_inst (
        .clk       (clk),
        .rstN      (rstN),
        .set       (set),
        .tag       (tag),
        .offset    (offset),
        .writeData (cacheWd),
        .memCtrl   (memCtrl),
        .lookup    (lookup),
        .way0Word  (way0Word),
        .way1Word  (way1Word)
    );

    cacheDatapath cacheDatapath_inst (
        .A        (A),
        .WD       (WD),
        .HRData   (HRData),
        .pathCtrl (pathCtrl),
        .lookup   (lookup),
        .way0Word (way0Word),
        .way1Word (way1Word),
        .set      (set),
        .tag      (tag),
        .offset   (offset),
        .cacheWd  (cacheWd),
        .HAddr    (HAddr),
        .HWData   (HWData),
        .RD       (RD)
    );

endmodule

/* tbClock.sv */
//--------------------
// Testbench clock and reset
// 100 ns clock, rstN held low for 5 cycles
//--------------------
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release 1 ns after the fifth rising edge, like other inputs
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

/* tbBusMemory.sv */
//--------------------
// Bus memory model
// 1024 words, one word per request, BusReady after
// a random delay of 0 to 3 cycles
//--------------------
`timescale 1ns/1ps

module tbBusMemory (
    input  logic           clk,
    input  logic           rstN,
    input  cachePkg::addrT HAddr,
    input  cachePkg::wordT HWData,
    input  logic           HRequestM,
    input  logic           HWriteM,
    output cachePkg::wordT HRData,
    output logic           BusReady
);
    import cachePkg::*;

    wordT        mem [0:1023];
    logic [31:0] lfsr;
    // Cycles left before the next pulse
    logic [1:0]  delayLeft;
    logic        armed;

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One step per delay bit
    task automatic drawDelay();
        for (int i = 0; i < 2; i++) begin
            delayLeft[i] = lfsr[0];
            lfsr = lfsrStep(lfsr);
        end
    endtask

    initial begin
        // Odd multiplier keeps every word distinct
        for (int i = 0; i < 1024; i++)
            mem[i] = (i * 32'h9E37_79B1) ^ {22'h0, 10'(i)};
        lfsr      = 32'h78b5;
        HRData    = '0;
        BusReady  = 1'b0;
        delayLeft = '0;
        armed     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (BusReady || !rstN || !HRequestM) begin
                // One-cycle pulse, then a fresh delay for the next word
                BusReady = 1'b0;
                armed    = 1'b0;
            end else begin
                if (!armed) begin
                    drawDelay();
                    armed = 1'b1;
                end
                if (delayLeft == 2'd0) begin
                    if (HWriteM)
                        mem[HAddr[11:2]] = HWData;
                    else
                        HRData = mem[HAddr[11:2]];
                    BusReady = 1'b1;
                end else begin
                    delayLeft = delayLeft - 1'b1;
                end
            end
        end
    end

endmodule

/* dataWritebackCacheTb.sv */
//--------------------
// Data cache testbench
// Drives loads and stores, keeps a shadow memory and
// checks the cache and bus with assertions
//--------------------
`timescale 1ns/1ps

module dataWritebackCacheTb;
    import cachePkg::*;

    logic     clk, rstN;
    logic     enable, MemWriteM, MemtoRegM, IStall;
    addrT     A, HAddr;
    wordT     WD, RD, HRData, HWData;
    byteMaskT ByteMask;
    logic     BusReady, Stall, HRequestM, HWriteM;

    // Expected memory contents after every committed store
    wordT shadow [0:1023];
    wordT expRd, expBusWord;
    int   errorCount = 0;
    int   testCount = 0;
    int   failCount = 0;
    int   writeBeats = 0;
    logic expectHit = 1'b0;
    logic evictCheck = 1'b0;
    addrT victimBlock = '0;

    assign expRd      = shadow[A[11:2]];
    assign expBusWord = shadow[HAddr[11:2]];

    tbClock clock_inst (.clk(clk), .rstN(rstN));

    dataWritebackCache dataWritebackCache_inst (
        .clk(clk), .rstN(rstN), .enable(enable),
        .MemWriteM(MemWriteM), .MemtoRegM(MemtoRegM), .IStall(IStall),
        .A(A), .WD(WD), .ByteMask(ByteMask),
        .HRData(HRData), .BusReady(BusReady),
        .RD(RD), .Stall(Stall), .HAddr(HAddr), .HWData(HWData),
        .HRequestM(HRequestM), .HWriteM(HWriteM)
    );

    tbBusMemory busMemory_inst (
        .clk(clk), .rstN(rstN), .HAddr(HAddr), .HWData(HWData),
        .HRequestM(HRequestM), .HWriteM(HWriteM),
        .HRData(HRData), .BusReady(BusReady)
    );

    task automatic logError(input string msg);
        $display("Error %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic endRun();
        $display("Tests %0d, failed %0d, errors %0d", testCount, failCount, errorCount);
        if (errorCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic finishTest(input string name, input int startErrors);
        testCount++;
        if (errorCount == startErrors) begin
            $display("Test %s: ok", name);
        end else begin
            failCount++;
            $display("Test %s: %0d errors", name, errorCount - startErrors);
        end
    endtask

    function automatic void applyStore(input addrT addr, input wordT data, input byteMaskT mask);
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    // Waits for rstN, then copies the bus memory into the shadow
    task automatic waitReset();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (rstN !== 1'b1 && cycles < 200);
        if (rstN !== 1'b1) begin
            $display("Reset never released within 200 cycles");
            errorCount++;
            endRun();
        end else begin
            for (int i = 0; i < 1024; i++)
                shadow[i] = busMemory_inst.mem[i];
        end
    endtask

    // Holds one access until Stall is low at a falling edge
    task automatic runAccess(input string name, input logic isStore, input addrT addr,
                             input wordT data, input byteMaskT mask);
        int cycles;
        A         = addr;
        WD        = data;
        ByteMask  = mask;
        MemWriteM = isStore;
        MemtoRegM = !isStore;
        cycles    = 0;
        @(negedge clk);
        while (Stall && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (Stall) begin
            $display("Access %s at %h hung with Stall high for 200 cycles", name, addr);
            errorCount++;
            endRun();
        end else begin
            // The access commits at this edge
            @(posedge clk);
            #1;
            if (isStore)
                applyStore(addr, data, mask);
            MemWriteM = 1'b0;
            MemtoRegM = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (rstN && enable && HRequestM && HWriteM && BusReady)
            writeBeats <= writeBeats + 1;
    end

    //--------------------
    // Checks
    //--------------------
    resetQuiet: assert property (@(posedge clk)
        (!rstN || $past(!rstN)) |-> (!Stall && !HRequestM && !HWriteM))
        else logError("Stall or bus request high around reset");

    loadData: assert property (@(posedge clk) disable iff (!rstN)
        (MemtoRegM && !Stall) |-> (RD == expRd))
        else logError($sformatf("load at %h returned %h, expected %h",
                                $sampled(A), $sampled(RD), $sampled(expRd)));

    hitQuiet: assert property (@(posedge clk) disable iff (!rstN)
        (expectHit && (MemWriteM || MemtoRegM)) |-> (!Stall && !HRequestM))
        else logError($sformatf("access at %h did not hit", $sampled(A)));

    // Write-back words carry the latest stored data
    writeBackData: assert property (@(posedge clk) disable iff (!rstN)
        (enable && HRequestM && HWriteM && BusReady) |-> (HWData == expBusWord))
        else logError($sformatf("write-back at %h sent %h, expected %h",
                                $sampled(HAddr), $sampled(HWData), $sampled(expBusWord)));

    writeBackAddr: assert property (@(posedge clk) disable iff (!rstN)
        (evictCheck && HWriteM && BusReady) |-> (HAddr[31:4] == victimBlock[31:4]))
        else logError($sformatf("write-back address %h outside victim block",
                                $sampled(HAddr)));

    uncachedAddr: assert property (@(posedge clk) disable iff (!rstN)
        (!enable && HRequestM) |-> (HAddr == A))
        else logError($sformatf("uncached bus address %h, expected %h",
                                $sampled(HAddr), $sampled(A)));

    // One word per uncached access
    uncachedSingle: assert property (@(posedge clk) disable iff (!rstN)
        (!enable && BusReady) |=> !HRequestM)
        else logError("uncached access made a second bus transfer");

    uncachedStore: assert property (@(posedge clk) disable iff (!rstN)
        (!enable && BusReady && MemWriteM) |-> (HWriteM && HWData == WD))
        else logError($sformatf("uncached store sent %h, expected %h",
                                $sampled(HWData), $sampled(WD)));

    //--------------------
    // Stimulus
    //--------------------
    initial begin
        int startErrors;
        int beatsBefore;
        enable    = 1'b1;
        MemWriteM = 1'b0;
        MemtoRegM = 1'b0;
        IStall    = 1'b0;
        A         = '0;
        WD        = '0;
        ByteMask  = '0;

        startErrors = errorCount;
        waitReset();
        repeat (2) @(posedge clk);
        #1;
        finishTest("reset", startErrors);

        // Set 1, critical word first, then hits on the rest
        startErrors = errorCount;
        runAccess("first load", 1'b0, 32'h118, '0, '0);
        expectHit = 1'b1;
        runAccess("hit load 0", 1'b0, 32'h110, '0, '0);
        runAccess("hit load 1", 1'b0, 32'h114, '0, '0);
        runAccess("hit load 3", 1'b0, 32'h11C, '0, '0);
        expectHit = 1'b0;
        finishTest("fill and hit", startErrors);

        startErrors = errorCount;
        expectHit = 1'b1;
        runAccess("partial store hit", 1'b1, 32'h114, 32'hA5A5_5A5A, 4'b0110);
        runAccess("merged load", 1'b0, 32'h114, '0, '0);
        expectHit = 1'b0;
        // Store miss into set 2
        runAccess("partial store miss", 1'b1, 32'h22C, 32'h0BAD_F00D, 4'b1001);
        expectHit = 1'b1;
        runAccess("merged load miss block", 1'b0, 32'h22C, '0, '0);
        expectHit = 1'b0;
        finishTest("partial store", startErrors);

        // Three tags in set 0, the dirty block is evicted
        startErrors = errorCount;
        runAccess("store X", 1'b1, 32'h048, 32'hDEAD_BEEF, 4'b1100);
        runAccess("load Y", 1'b0, 32'h144, '0, '0);
        victimBlock = 32'h040;
        evictCheck  = 1'b1;
        beatsBefore = writeBeats;
        runAccess("load Z", 1'b0, 32'h24C, '0, '0);
        evictCheck = 1'b0;
        beatCount: assert (writeBeats - beatsBefore == 4)
            else logError($sformatf("%0d write-back words, expected 4",
                                    writeBeats - beatsBefore));
        runAccess("reload X", 1'b0, 32'h048, '0, '0);
        runAccess("reload X word 0", 1'b0, 32'h040, '0, '0);
        finishTest("dirty eviction", startErrors);

        // Addresses never cached
        startErrors = errorCount;
        enable = 1'b0;
        runAccess("uncached load", 1'b0, 32'h800, '0, '0);
        runAccess("uncached store", 1'b1, 32'h804, 32'h1234_5678, 4'hF);
        busWrite: assert (busMemory_inst.mem[32'h804 >> 2] == 32'h1234_5678)
            else logError($sformatf("bus memory holds %h after uncached store",
                                    busMemory_inst.mem[32'h804 >> 2]));
        runAccess("uncached load back", 1'b0, 32'h804, '0, '0);
        enable = 1'b1;
        finishTest("uncached", startErrors);

        endRun();
    end

endmodule

/* src.f */
cachePkg.sv
cacheController.sv
cacheMemory.sv
cacheDatapath.sv
dataWritebackCache.sv
tbClock.sv
tbBusMemory.sv
dataWritebackCacheTb.sv

/* Bender.yml */
package:
  name: dataWritebackCache

sources:
  # Design
  - files:
      - cachePkg.sv
      - cacheController.sv
      - cacheMemory.sv
      - cacheDatapath.sv
      - dataWritebackCache.sv

  # Testbench
  - target: test
    files:
      - tbClock.sv
      - tbBusMemory.sv
      - dataWritebackCacheTb.sv
